// File: source/ql_defs.svh
`ifndef QL_DEFS_SVH
`define QL_DEFS_SVH

// --------------------
// bus widths
// --------------------
`define QL_CPU_AW        20        // 68008 style 1MB address space
`define QL_SDRAM_AW      25        // sdram word address
`define QL_VIDEO_AW      19        // zx8301 word address
`define QL_DW            16        // cpu and sdram data
`define QL_DIO_IW        5         // download index from data io

// reset stretch counter, all ones gives 4095 cycles
`define QL_RESET_CNT_W   12

// --------------------
// address fields
// --------------------
`define QL_IO_PAGE       6'd6      // $18000-$1bfff, bits 19:14
`define QL_QIMI_PAGE     6'h3f     // qimi mouse at $1bfxx, bits 13:8
`define QL_QLSD_REG      16'hfee4  // only ql-sd register that returns data

// download index values
`define QL_DL_ROM0       5'd0      // system rom
`define QL_DL_MDV1       5'd1      // microdrive 1 image
`define QL_DL_MDV2       5'd2      // microdrive 2 image
`define QL_DL_ROM3       5'd3      // alternate rom

`endif

// File: source/ql_pkg.sv
`default_nettype none

package ql_pkg;

	// memory map view of a cpu address
	typedef struct packed {
		logic [3:0]  region;  // 64k region, bits 19:16
		logic        bank;    // bit 15
		logic [14:0] offset;  // bits 14:0
	} ql_mem_addr_t;

	// io view, only the bits the io decode looks at are named
	typedef struct packed {
		logic [5:0] io_page;  // bits 19:14
		logic [5:0] io_sub;   // bits 13:8
		logic       pad7;
		logic       a6;       // zx8301 / zx8302 split
		logic       a5;
		logic [2:0] pad4_2;
		logic       a1;
		logic       a0;
	} ql_io_addr_t;

	// one cpu address, decoded both ways
	typedef union packed {
		ql_mem_addr_t mem;
		ql_io_addr_t  io;
	} ql_addr_u;

	// tg68k busstate encoding
	typedef enum logic [1:0] {
		BS_FETCH = 2'b00,  // code fetch
		BS_IDLE  = 2'b01,  // no memory access
		BS_READ  = 2'b10,  // data read
		BS_WRITE = 2'b11   // data write
	} ql_busstate_e;

endpackage

`default_nettype wire

// File: source/ql_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module ql_addr_decode
	import ql_pkg::*;
(
	input  ql_addr_u     cpu_addr,
	input  ql_busstate_e cpu_busstate,
	input  logic         cpu_rw,        // low on write
	input  logic         cpu_uds_n,
	input  logic         cpu_lds_n,
	input  logic         ram_640k,      // expansion ram enabled
	input  logic         video_cycle,   // current slot belongs to video
	output logic         cpu_rd,
	output logic         cpu_wr,
	output logic         cpu_lds,
	output logic         cpu_uds,
	output logic         cpu_rom,
	output logic         cpu_ram,
	output logic         cpu_mem,
	output logic         cpu_io,
	output logic         zx8301_cs,
	output logic         zx8302_sel,
	output logic         qimi_sel,
	output logic         qlsd_rd
);

	logic cpu_act;   // any bus activity
	logic cpu_bram;  // base ram hit
	logic cpu_xram;  // expansion ram hit
	logic cpu_cycle; // cpu owns this slot

	// --------------------
	// bus state
	// --------------------
	assign cpu_rd  = (cpu_busstate == BS_FETCH) || (cpu_busstate == BS_READ);
	assign cpu_wr  = (cpu_busstate == BS_WRITE) && !cpu_rw;
	assign cpu_uds = !cpu_uds_n;
	assign cpu_lds = !cpu_lds_n;
	assign cpu_act = cpu_rd || cpu_wr;

	assign cpu_cycle = !video_cycle;

	// --------------------
	// memory map
	// --------------------
	assign cpu_rom  = cpu_act && (cpu_addr.mem.region == 4'h0);       // 64k rom at $0
	assign cpu_bram = cpu_act && (cpu_addr.mem.region[3:1] == 3'b001); // 128k at $20000
	// regions 4..b, 512k at $40000
	assign cpu_xram = cpu_act && ram_640k &&
		(cpu_addr.mem.region >= 4'h4) && (cpu_addr.mem.region <= 4'hb);
	assign cpu_ram  = cpu_bram || cpu_xram;
	assign cpu_mem  = cpu_ram || cpu_rom;     // anything served by sdram
	assign cpu_io   = cpu_act && (cpu_addr.io.io_page == `QL_IO_PAGE);

	// --------------------
	// io selects
	// --------------------
	assign qimi_sel   = cpu_io && (cpu_addr.io.io_sub == `QL_QIMI_PAGE);
	assign zx8302_sel = cpu_cycle && cpu_io && !cpu_addr.io.a6;

	// zx8301 only has the write-only mode register at $18063
	assign zx8301_cs  = cpu_cycle && cpu_io &&
		cpu_addr.io.a6 && cpu_addr.io.a5 && cpu_addr.io.a1 &&
		cpu_wr && cpu_lds;

	// ql-sd sits in the rom area, one readable register
	assign qlsd_rd = cpu_rom &&
		({cpu_addr.mem.bank, cpu_addr.mem.offset} == `QL_QLSD_REG);

endmodule

`default_nettype wire

// File: source/ql_read_mux.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module ql_read_mux
	import ql_pkg::*;
(
	input  ql_addr_u                 cpu_addr,
	input  logic                     qlsd_rd,
	input  logic                     cpu_mem,
	input  logic                     cpu_io,
	input  logic                     qimi_sel,
	input  logic [`QL_DW-1:0]        sdram_dout,
	input  logic [`QL_DW-1:0]        zx8302_dout,
	input  logic [`QL_DW/2-1:0]      qimi_data,   // byte wide device
	input  logic [`QL_DW/2-1:0]      qlsd_dout,   // byte wide device
	output logic [`QL_DW-1:0]        cpu_din
);

	logic [`QL_DW-1:0] io_dout;

	// io space read data
	always_comb begin
		if (qimi_sel)
			io_dout = {qimi_data, qimi_data};  // byte on both lanes
		else if (!cpu_addr.io.a6)
			io_dout = zx8302_dout;
		else
			io_dout = '0;                      // zx8301 is write only
	end

	// --------------------
	// cpu data in
	// --------------------
	always_comb begin
		if (qlsd_rd)
			cpu_din = {qlsd_dout, qlsd_dout};  // overlays the rom
		else if (cpu_mem)
			cpu_din = sdram_dout;
		else if (cpu_io)
			cpu_din = io_dout;
		else
			cpu_din = '1;                      // open bus
	end

endmodule

`default_nettype wire

// File: source/ql_slot_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module ql_slot_arbiter
	import ql_pkg::*;
(
	input  logic                     clk2,
	input  logic                     rst_n,
	input  logic [`QL_CPU_AW-1:0]    cpu_addr,
	input  logic [`QL_DW-1:0]        cpu_dout,
	input  logic                     cpu_uds,
	input  logic                     cpu_lds,
	input  logic                     cpu_rd,
	input  logic                     cpu_wr,
	input  logic                     cpu_ram,
	input  logic                     cpu_mem,
	input  ql_busstate_e             cpu_busstate,
	input  logic                     dio_download,
	input  logic [`QL_SDRAM_AW-1:0]  dio_addr,
	input  logic [`QL_DW-1:0]        dio_data,
	input  logic                     dio_write,
	input  logic [`QL_VIDEO_AW-1:0]  video_addr,
	input  logic                     video_rd,
	input  logic                     mdv_read,
	input  logic                     mdv2_read,
	input  logic                     mdv_seldrive,  // 1 selects mdv2
	input  logic [`QL_SDRAM_AW-1:0]  mdv_addr,
	input  logic [`QL_SDRAM_AW-1:0]  mdv2_addr,
	input  logic                     ram_delay_dtack,
	output logic                     video_cycle,
	output logic                     cpu_enable,
	output logic [`QL_SDRAM_AW-1:0]  sdram_addr,
	output logic                     sdram_wr,
	output logic                     sdram_oe,
	output logic                     sdram_uds,
	output logic                     sdram_lds,
	output logic [`QL_DW-1:0]        sdram_din
);

	logic                    cpu_idle;
	logic                    mdv_any;    // either drive wants the slot
	logic [`QL_SDRAM_AW-1:0] vid_addr;   // video slot request
	logic                    vid_oe;
	logic [`QL_SDRAM_AW-1:0] sys_addr;   // cpu / download slot request
	logic                    sys_wr;
	logic                    sys_oe;
	logic                    sys_uds;
	logic                    sys_lds;

	assign cpu_idle = (cpu_busstate == BS_IDLE);

	// --------------------
	// slot toggle
	// --------------------
	always_ff @(posedge clk2 or negedge rst_n) begin
		if (!rst_n)
			video_cycle <= 1'b0;  // cpu gets the first slot
		else
			video_cycle <= !video_cycle;
	end

	// microdrive steals the video slot, one drive at a time
	assign mdv_any  = mdv_read || mdv2_read;
	assign vid_addr = mdv_any ? (mdv_seldrive ? mdv2_addr : mdv_addr) :
		{{(`QL_SDRAM_AW-`QL_VIDEO_AW){1'b0}}, video_addr};
	assign vid_oe   = mdv_any || video_rd;

	// download owns the cpu slot while it runs
	assign sys_addr = dio_download ? dio_addr :
		{{(`QL_SDRAM_AW-`QL_CPU_AW+1){1'b0}}, cpu_addr[`QL_CPU_AW-1:1]};  // word address
	assign sys_wr   = dio_download ? dio_write : (cpu_wr && cpu_ram);
	assign sys_oe   = dio_download ? 1'b0 : (cpu_rd && cpu_mem);
	assign sys_uds  = dio_download || cpu_uds;
	assign sys_lds  = dio_download || cpu_lds;

	// --------------------
	// sdram request
	// --------------------
	assign sdram_addr = video_cycle ? vid_addr : sys_addr;
	assign sdram_wr   = video_cycle ? 1'b0 : sys_wr;      // video never writes
	assign sdram_oe   = video_cycle ? vid_oe : sys_oe;
	assign sdram_uds  = video_cycle || sys_uds;
	assign sdram_lds  = video_cycle || sys_lds;
	assign sdram_din  = dio_download ? dio_data : cpu_dout;

	// cpu runs in its own slot, or when it does not touch the bus
	always_ff @(posedge clk2 or negedge rst_n) begin
		if (!rst_n)
			cpu_enable <= 1'b0;
		else
			cpu_enable <= ((!video_cycle && !dio_download) || cpu_idle) && !ram_delay_dtack;
	end

endmodule

`default_nettype wire

// File: source/ql_reset_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module ql_reset_gen (
	input  logic                   clk2,
	input  logic                   rst_n,
	input  logic                   button_reset,
	input  logic                   osd_reset,
	input  logic                   dio_download,
	input  logic [`QL_DIO_IW-1:0]  dio_index,
	output logic                   sys_reset,
	output logic                   mdv_download,
	output logic                   mdv2_download
);

	logic [`QL_RESET_CNT_W-1:0] reset_cnt;
	logic                       rom_download;  // new rom restarts the machine

	// --------------------
	// download index decode
	// --------------------
	assign rom_download  = dio_download &&
		((dio_index == `QL_DL_ROM0) || (dio_index == `QL_DL_ROM3));
	assign mdv_download  = dio_download && (dio_index == `QL_DL_MDV1);
	assign mdv2_download = dio_download && (dio_index == `QL_DL_MDV2);

	// reload on any request, then count down to zero
	always_ff @(posedge clk2 or negedge rst_n) begin
		if (!rst_n)
			reset_cnt <= '1;
		else if (button_reset || osd_reset || rom_download)
			reset_cnt <= '1;
		else if (reset_cnt != '0)
			reset_cnt <= reset_cnt - 1'b1;
	end

	assign sys_reset = (reset_cnt != '0);

endmodule

`default_nettype wire

// File: source/ql_bus_glue.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module ql_bus_glue
	import ql_pkg::*;
(
	input  logic                     clk2,
	input  logic                     rst_n,
	// cpu side
	input  ql_addr_u                 cpu_addr,
	input  ql_busstate_e             cpu_busstate,
	input  logic                     cpu_rw,
	input  logic                     cpu_uds_n,
	input  logic                     cpu_lds_n,
	input  logic [`QL_DW-1:0]        cpu_dout,
	output logic [`QL_DW-1:0]        cpu_din,
	output logic                     cpu_enable,
	output logic                     cpu_wr,
	output logic                     cpu_uds,
	output logic                     cpu_lds,
	output logic                     cpu_rom,   // rom read window for ql-sd
	input  logic                     ram_640k,
	// download port
	input  logic                     dio_download,
	input  logic [`QL_DIO_IW-1:0]    dio_index,
	input  logic [`QL_SDRAM_AW-1:0]  dio_addr,
	input  logic [`QL_DW-1:0]        dio_data,
	input  logic                     dio_write,
	// video and microdrive
	input  logic [`QL_VIDEO_AW-1:0]  video_addr,
	input  logic                     video_rd,
	input  logic                     mdv_read,
	input  logic                     mdv2_read,
	input  logic                     mdv_seldrive,
	input  logic [`QL_SDRAM_AW-1:0]  mdv_addr,
	input  logic [`QL_SDRAM_AW-1:0]  mdv2_addr,
	output logic                     video_cycle,
	output logic                     mdv_download,
	output logic                     mdv2_download,
	// device read data and selects
	input  logic [`QL_DW-1:0]        sdram_dout,
	input  logic [`QL_DW-1:0]        zx8302_dout,
	input  logic [`QL_DW/2-1:0]      qimi_data,
	input  logic [`QL_DW/2-1:0]      qlsd_dout,
	output logic                     zx8301_cs,
	output logic                     zx8302_sel,
	output logic                     qimi_sel,
	output logic                     qlsd_rd,
	// sdram request
	output logic [`QL_SDRAM_AW-1:0]  sdram_addr,
	output logic                     sdram_wr,
	output logic                     sdram_oe,
	output logic                     sdram_uds,
	output logic                     sdram_lds,
	output logic [`QL_DW-1:0]        sdram_din,
	// reset
	input  logic                     ram_delay_dtack,
	input  logic                     button_reset,
	input  logic                     osd_reset,
	output logic                     sys_reset
);

	// --------------------
	// decoder results
	// --------------------
	logic cpu_rd;
	logic cpu_ram;
	logic cpu_mem;
	logic cpu_io;

	ql_addr_decode u_addr_decode (
		.cpu_addr     (cpu_addr),
		.cpu_busstate (cpu_busstate),
		.cpu_rw       (cpu_rw),
		.cpu_uds_n    (cpu_uds_n),
		.cpu_lds_n    (cpu_lds_n),
		.ram_640k     (ram_640k),
		.video_cycle  (video_cycle),
		.cpu_rd       (cpu_rd),
		.cpu_wr       (cpu_wr),
		.cpu_lds      (cpu_lds),
		.cpu_uds      (cpu_uds),
		.cpu_rom      (cpu_rom),
		.cpu_ram      (cpu_ram),
		.cpu_mem      (cpu_mem),
		.cpu_io       (cpu_io),
		.zx8301_cs    (zx8301_cs),
		.zx8302_sel   (zx8302_sel),
		.qimi_sel     (qimi_sel),
		.qlsd_rd      (qlsd_rd)
	);

	ql_read_mux u_read_mux (
		.cpu_addr    (cpu_addr),
		.qlsd_rd     (qlsd_rd),
		.cpu_mem     (cpu_mem),
		.cpu_io      (cpu_io),
		.qimi_sel    (qimi_sel),
		.sdram_dout  (sdram_dout),
		.zx8302_dout (zx8302_dout),
		.qimi_data   (qimi_data),
		.qlsd_dout   (qlsd_dout),
		.cpu_din     (cpu_din)
	);

	// video and cpu/download share the single sdram port
	ql_slot_arbiter u_slot_arbiter (
		.clk2            (clk2),
		.rst_n           (rst_n),
		.cpu_addr        (cpu_addr),
		.cpu_dout        (cpu_dout),
		.cpu_uds         (cpu_uds),
		.cpu_lds         (cpu_lds),
		.cpu_rd          (cpu_rd),
		.cpu_wr          (cpu_wr),
		.cpu_ram         (cpu_ram),
		.cpu_mem         (cpu_mem),
		.cpu_busstate    (cpu_busstate),
		.dio_download    (dio_download),
		.dio_addr        (dio_addr),
		.dio_data        (dio_data),
		.dio_write       (dio_write),
		.video_addr      (video_addr),
		.video_rd        (video_rd),
		.mdv_read        (mdv_read),
		.mdv2_read       (mdv2_read),
		.mdv_seldrive    (mdv_seldrive),
		.mdv_addr        (mdv_addr),
		.mdv2_addr       (mdv2_addr),
		.ram_delay_dtack (ram_delay_dtack),
		.video_cycle     (video_cycle),
		.cpu_enable      (cpu_enable),
		.sdram_addr      (sdram_addr),
		.sdram_wr        (sdram_wr),
		.sdram_oe        (sdram_oe),
		.sdram_uds       (sdram_uds),
		.sdram_lds       (sdram_lds),
		.sdram_din       (sdram_din)
	);

	ql_reset_gen u_reset_gen (
		.clk2          (clk2),
		.rst_n         (rst_n),
		.button_reset  (button_reset),
		.osd_reset     (osd_reset),
		.dio_download  (dio_download),
		.dio_index     (dio_index),
		.sys_reset     (sys_reset),
		.mdv_download  (mdv_download),
		.mdv2_download (mdv2_download)
	);

endmodule

`default_nettype wire

// File: sim/tb_ql_bus_glue.sv
`timescale 1ns/1ns
`default_nettype none

`include "ql_defs.svh"

module tb_ql_bus_glue
	import ql_pkg::*;
();

	// --------------------
	// run length
	// --------------------
	localparam int N_DECODE = 200;
	localparam int N_IO     = 100;
	localparam int N_CPU    = 100;
	localparam int N_VIDEO  = 100;
	localparam int N_DL     = 10;    // per download index
	localparam int N_DTACK  = 20;
	localparam int STRETCH  = 4095;  // reset counter all ones
	localparam int TEST_CYCLES = 3 + N_DECODE + N_IO + N_CPU + N_VIDEO + 4 * N_DL + N_DTACK + 20;
	localparam int MAX_CYCLES  = STRETCH + 2 * TEST_CYCLES;  // stretch plus twice the tests

	// compare modes
	localparam int M_NONE = 0, M_DECODE = 1, M_IO = 2, M_CPU = 3, M_VID = 4, M_DL = 5, M_DTACK = 6;

	// bit positions in the expected decode word
	localparam int D_RD = 9, D_WR = 8, D_ROM = 7, D_RAM = 6, D_MEM = 5, D_IO = 4;
	localparam int D_QIMI = 3, D_ZX2 = 2, D_ZX1 = 1, D_QLSD = 0;

	logic clk2;
	logic rst_n;
	logic [`QL_CPU_AW-1:0]   cpu_addr;   // ties straight onto the union port
	ql_busstate_e            cpu_busstate;
	logic                    cpu_rw, cpu_uds_n, cpu_lds_n;
	logic [`QL_DW-1:0]       cpu_dout, cpu_din;
	logic                    cpu_enable, cpu_wr, cpu_uds, cpu_lds, cpu_rom;
	logic                    ram_640k;
	logic                    dio_download, dio_write;
	logic [`QL_DIO_IW-1:0]   dio_index;
	logic [`QL_SDRAM_AW-1:0] dio_addr, mdv_addr, mdv2_addr, sdram_addr;
	logic [`QL_DW-1:0]       dio_data, sdram_dout, zx8302_dout, sdram_din;
	logic [`QL_VIDEO_AW-1:0] video_addr;
	logic                    video_rd, mdv_read, mdv2_read, mdv_seldrive;
	logic                    video_cycle, mdv_download, mdv2_download;
	logic [`QL_DW/2-1:0]     qimi_data, qlsd_dout;
	logic                    zx8301_cs, zx8302_sel, qimi_sel, qlsd_rd;
	logic                    sdram_wr, sdram_oe, sdram_uds, sdram_lds;
	logic                    ram_delay_dtack, button_reset, osd_reset, sys_reset;

	integer      seed = 63522;
	int          mode;
	int          err_cnt, chk_cnt, err_start, chk_start;
	int          cycle_cnt;
	int          stretch;
	logic        exp_vc;              // slot model toggling every clock
	logic        en_exp, en_valid;    // cpu_enable one cycle behind
	logic        dtack_prev, dl_prev;
	logic [9:0]  dec_exp;
	logic [44:0] req_exp;             // addr, wr, oe, uds, lds, din

	ql_bus_glue u_ql_bus_glue (.*);

	initial begin
		clk2 = 1'b0;
		forever #5 clk2 = ~clk2;
	end

	// --------------------
	// reference model
	// --------------------
	function automatic logic [9:0] ref_decode(input logic [19:0] a, input logic [1:0] bs,
		input logic rw, input logic lds_n, input logic x640, input logic vc);
		logic       rd, wr, act, rom, ram, io;
		logic [9:0] d;
		rd  = (bs == 2'b00) || (bs == 2'b10);   // fetch or data read
		wr  = (bs == 2'b11) && !rw;
		act = rd || wr;
		rom = act && (a[19:16] == 4'h0);
		ram = act && ((a[19:17] == 3'b001) ||
			(x640 && a[19:16] >= 4'h4 && a[19:16] <= 4'hb));
		io  = act && (a[19:14] == 6'd6);
		d[D_RD]   = rd;
		d[D_WR]   = wr;
		d[D_ROM]  = rom;
		d[D_RAM]  = ram;
		d[D_MEM]  = ram || rom;
		d[D_IO]   = io;
		d[D_QIMI] = io && (a[13:8] == 6'h3f);
		d[D_ZX2]  = !vc && io && !a[6];
		d[D_ZX1]  = !vc && io && a[6] && a[5] && a[1] && wr && !lds_n;  // mode reg write
		d[D_QLSD] = rom && (a[15:0] == 16'hfee4);
		return d;
	endfunction

	function automatic logic [15:0] ref_din(input logic [9:0] d, input logic [19:0] a);
		if (d[D_QLSD])
			return {qlsd_dout, qlsd_dout};
		if (d[D_MEM])
			return sdram_dout;
		if (d[D_IO]) begin
			if (d[D_QIMI])
				return {qimi_data, qimi_data};
			return a[6] ? 16'h0000 : zx8302_dout;
		end
		return 16'hffff;   // nothing answers
	endfunction

	function automatic logic [44:0] ref_sdram(input logic vc, input logic [9:0] d);
		logic [24:0] addr;
		logic        wr, oe, uds, lds;
		logic [15:0] din;
		din = dio_download ? dio_data : cpu_dout;
		if (vc) begin
			if (mdv_read || mdv2_read)
				addr = mdv_seldrive ? mdv2_addr : mdv_addr;
			else
				addr = {6'd0, video_addr};
			wr  = 1'b0;
			oe  = mdv_read || mdv2_read || video_rd;
			uds = 1'b1;
			lds = 1'b1;
		end else if (dio_download) begin
			addr = dio_addr;
			wr   = dio_write;
			oe   = 1'b0;
			uds  = 1'b1;
			lds  = 1'b1;
		end else begin
			addr = {6'd0, cpu_addr[19:1]};   // word address
			wr   = d[D_WR] && d[D_RAM];
			oe   = d[D_RD] && d[D_MEM];
			uds  = !cpu_uds_n;
			lds  = !cpu_lds_n;
		end
		return {addr, wr, oe, uds, lds, din};
	endfunction

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		err_cnt++;
		$display("ERROR %s: got %h, expected %h at %0t", sig, got, exp, $time);
	endtask

	task automatic compare_sdram();
		chk_cnt++;
		if (sdram_addr !== req_exp[44:20]) report_mismatch("sdram_addr", sdram_addr, req_exp[44:20]);
		if (sdram_wr !== req_exp[19])      report_mismatch("sdram_wr", sdram_wr, req_exp[19]);
		if (sdram_oe !== req_exp[18])      report_mismatch("sdram_oe", sdram_oe, req_exp[18]);
		if (sdram_uds !== req_exp[17])     report_mismatch("sdram_uds", sdram_uds, req_exp[17]);
		if (sdram_lds !== req_exp[16])     report_mismatch("sdram_lds", sdram_lds, req_exp[16]);
		if (sdram_din !== req_exp[15:0])   report_mismatch("sdram_din", sdram_din, req_exp[15:0]);
	endtask

	// --------------------
	// compare process
	// --------------------
	always begin
		@(negedge clk2);
		#4;                                    // inputs settled and next posedge still ahead
		if (!rst_n) begin
			exp_vc   = 1'b0;
			en_valid = 1'b0;
		end else begin
			dec_exp = ref_decode(cpu_addr, cpu_busstate, cpu_rw, cpu_lds_n, ram_640k, exp_vc);
			req_exp = ref_sdram(exp_vc, dec_exp);
			chk_cnt++;
			if (video_cycle !== exp_vc) report_mismatch("video_cycle", video_cycle, exp_vc);
			if (en_valid) begin
				chk_cnt++;
				if (cpu_enable !== en_exp) report_mismatch("cpu_enable", cpu_enable, en_exp);
			end
			case (mode)
				M_DECODE: begin
					chk_cnt++;
					if (cpu_din !== ref_din(dec_exp, cpu_addr))
						report_mismatch("cpu_din", cpu_din, ref_din(dec_exp, cpu_addr));
					if (cpu_rom !== dec_exp[D_ROM])
						report_mismatch("cpu_rom", cpu_rom, dec_exp[D_ROM]);
					if (cpu_wr !== dec_exp[D_WR])
						report_mismatch("cpu_wr", cpu_wr, dec_exp[D_WR]);
					if (cpu_uds !== !cpu_uds_n)
						report_mismatch("cpu_uds", cpu_uds, !cpu_uds_n);
					if (cpu_lds !== !cpu_lds_n)
						report_mismatch("cpu_lds", cpu_lds, !cpu_lds_n);
					if (qlsd_rd !== dec_exp[D_QLSD])
						report_mismatch("qlsd_rd", qlsd_rd, dec_exp[D_QLSD]);
				end
				M_IO: begin
					chk_cnt++;
					if (zx8301_cs !== dec_exp[D_ZX1])
						report_mismatch("zx8301_cs", zx8301_cs, dec_exp[D_ZX1]);
					if (zx8302_sel !== dec_exp[D_ZX2])
						report_mismatch("zx8302_sel", zx8302_sel, dec_exp[D_ZX2]);
					if (qimi_sel !== dec_exp[D_QIMI])
						report_mismatch("qimi_sel", qimi_sel, dec_exp[D_QIMI]);
					if (qlsd_rd !== dec_exp[D_QLSD])
						report_mismatch("qlsd_rd", qlsd_rd, dec_exp[D_QLSD]);
					if (exp_vc && (zx8301_cs || zx8302_sel)) begin
						err_cnt++;
						$display("zx8301 or zx8302 select went high in a video slot at %0t", $time);
					end
				end
				M_CPU: if (!exp_vc) compare_sdram();
				M_VID: if (exp_vc) compare_sdram();
				M_DL: begin
					compare_sdram();
					if (mdv_download !== (dio_index == 5'd1))
						report_mismatch("mdv_download", mdv_download, dio_index == 5'd1);
					if (mdv2_download !== (dio_index == 5'd2))
						report_mismatch("mdv2_download", mdv2_download, dio_index == 5'd2);
					if (!exp_vc && dl_prev && cpu_enable !== 1'b0)
						report_mismatch("cpu_enable", cpu_enable, 0);
				end
				M_DTACK: begin
					if (dtack_prev && cpu_enable !== 1'b0)
						report_mismatch("cpu_enable", cpu_enable, 0);
				end
				default: ;
			endcase
			// next clock registers this condition
			en_exp     = ((!exp_vc && !dio_download) || (cpu_busstate == BS_IDLE)) &&
				!ram_delay_dtack;
			en_valid   = 1'b1;
			dtack_prev = ram_delay_dtack;
			dl_prev    = dio_download;
			exp_vc     = !exp_vc;
		end
	end

	// --------------------
	// stimulus helpers
	// --------------------
	function automatic logic [19:0] pick_addr(input int kind);
		logic [31:0] r;
		r = $random(seed);
		case (kind % 5)
			0: return r[19:0];
			1: return {4'h0, r[15:0]};                       // rom
			2: return {6'd6, r[13:0]};                       // io page
			3: return 20'h0fee4;                             // ql-sd register
			default: return {4'h4 + {1'b0, r[18:16]}, r[15:0]};  // expansion window
		endcase
	endfunction

	task automatic drive_cpu(input logic [19:0] a);
		logic [31:0] r;
		r = $random(seed);
		cpu_addr     = a;
		cpu_busstate = ql_busstate_e'(r[1:0]);
		cpu_rw       = r[2];
		cpu_uds_n    = r[3];
		cpu_lds_n    = r[4];
		cpu_dout     = r[20:5];
	endtask

	task automatic drive_video();
		logic [31:0] r, r2;
		r  = $random(seed);
		r2 = $random(seed);
		video_addr   = r[18:0];
		video_rd     = r[19];
		mdv_read     = r[20];
		mdv2_read    = r[21];
		mdv_seldrive = r[22];   // 1 picks drive 2
		mdv_addr     = r2[24:0];
		mdv2_addr    = {r2[12:0], r2[31:20]};
	endtask

	task automatic start_test();
		err_start = err_cnt;
		chk_start = chk_cnt;
	endtask

	task automatic end_test(input string name);
		@(negedge clk2);
		mode = M_NONE;
		$display("%-22s done, %0d checks, %0d errors", name, chk_cnt - chk_start,
			err_cnt - err_start);
	endtask

	// --------------------
	// stimulus
	// --------------------
	initial begin
		logic [31:0] r;
		logic [1:0]  bs;
		logic [19:0] io_a;
		rst_n = 1'b0;
		mode  = M_NONE;
		err_cnt = 0;
		chk_cnt = 0;
		cpu_addr = '0;
		cpu_busstate = BS_IDLE;
		cpu_rw = 1'b1;
		cpu_uds_n = 1'b1;
		cpu_lds_n = 1'b1;
		cpu_dout = '0;
		ram_640k = 1'b0;
		dio_download = 1'b0;
		dio_index = '0;
		dio_addr = '0;
		dio_data = '0;
		dio_write = 1'b0;
		video_addr = '0;
		video_rd = 1'b0;
		mdv_read = 1'b0;
		mdv2_read = 1'b0;
		mdv_seldrive = 1'b0;
		mdv_addr = '0;
		mdv2_addr = '0;
		sdram_dout  = 16'h5aa5;   // distinct per device
		zx8302_dout = 16'h1234;
		qimi_data   = 8'hc3;
		qlsd_dout   = 8'h7e;
		ram_delay_dtack = 1'b0;
		button_reset = 1'b0;
		osd_reset = 1'b0;

		repeat (3) @(posedge clk2);
		@(negedge clk2);
		rst_n = 1'b1;
		chk_cnt++;
		if (sys_reset !== 1'b1) report_mismatch("sys_reset", sys_reset, 1);

		start_test();   // test 1 memory map and read mux
		for (int i = 0; i < N_DECODE; i++) begin
			@(negedge clk2);
			ram_640k = i[0];
			drive_cpu(pick_addr(i));
			mode = M_DECODE;
		end
		end_test("memory-map decode");

		start_test();   // test 2 io selects
		for (int i = 0; i < N_IO; i++) begin
			@(negedge clk2);
			r = $random(seed);
			io_a = {6'd6, (r[31] ? 6'h3f : r[13:8]), r[7:0]};
			if (r[30])
				io_a = io_a | 20'h00062;   // a6, a5 and a1 of the zx8301 mode register
			drive_cpu(io_a);
			if (r[29]) begin
				cpu_busstate = BS_WRITE;   // low byte write
				cpu_rw       = 1'b0;
				cpu_lds_n    = 1'b0;
			end
			mode = M_IO;
		end
		end_test("io selects");

		start_test();   // test 3 cpu slot requests
		for (int i = 0; i < N_CPU; i++) begin
			@(negedge clk2);
			ram_640k = i[1];
			drive_cpu(pick_addr(i));
			mode = M_CPU;
		end
		end_test("cpu-slot sdram");

		start_test();   // test 4 video and microdrive slot
		for (int i = 0; i < N_VIDEO; i++) begin
			@(negedge clk2);
			drive_video();
			drive_cpu(pick_addr(i));
			mode = M_VID;
		end
		end_test("video-slot sdram");

		start_test();   // test 5 download with every index
		for (int idx = 0; idx < 4; idx++) begin
			for (int i = 0; i < N_DL; i++) begin
				@(negedge clk2);
				r = $random(seed);
				dio_download = 1'b1;
				dio_index    = idx[4:0];
				dio_data     = r[15:0];
				dio_write    = r[16];
				bs           = (r[18:17] == 2'b01) ? 2'b10 : r[18:17];  // cpu never idle here
				cpu_busstate = ql_busstate_e'(bs);
				r = $random(seed);
				dio_addr     = r[24:0];
				mode = M_DL;
			end
		end
		end_test("download");
		dio_download = 1'b0;

		start_test();   // test 6 dtack stall then reset stretch
		for (int i = 0; i < N_DTACK; i++) begin
			@(negedge clk2);
			ram_delay_dtack = 1'b1;
			drive_cpu(pick_addr(i));
			mode = M_DTACK;
		end
		@(negedge clk2);
		mode = M_NONE;
		ram_delay_dtack = 1'b0;
		osd_reset = 1'b1;
		@(negedge clk2);
		osd_reset = 1'b0;      // counter reloaded on the edge just gone
		stretch = 0;
		while (sys_reset) begin
			@(negedge clk2);
			stretch++;
		end
		chk_cnt++;
		if (stretch != STRETCH) report_mismatch("sys_reset stretch", stretch, STRETCH);
		end_test("reset and enable");

		@(negedge clk2);
		$display("total %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// cycle limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk2);
			cycle_cnt++;
		end
		$display("run did not finish within %0d cycles", MAX_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+source
source/ql_pkg.sv
source/ql_addr_decode.sv
source/ql_read_mux.sv
source/ql_slot_arbiter.sv
source/ql_reset_gen.sv
source/ql_bus_glue.sv
sim/tb_ql_bus_glue.sv

// File: Bender.yml
package:
  name: ql_bus_glue

export_include_dirs:
  - source

sources:
  - files:
      - source/ql_pkg.sv
      - source/ql_addr_decode.sv
      - source/ql_read_mux.sv
      - source/ql_slot_arbiter.sv
      - source/ql_reset_gen.sv
      - source/ql_bus_glue.sv
  - target: test
    files:
      - sim/tb_ql_bus_glue.sv
